/* Bender.yml */
package:
  name: decode_unit

sources:
  - include_dirs:
      - include
    files:
      - design/isaPkg.sv
      - design/flowPkg.sv
      - design/ctrlIf.sv
      - design/instrQueue.sv
      - design/controlDecoder.sv
      - design/immExtender.sv
      - design/creditCounter.sv
      - design/issueSequencer.sv
      - design/decodeUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/decodeUnitTb.sv

/* design/controlDecoder.sv */
// Combinational opcode decoder driving the control bundle
`timescale 1ns/1ps

module controlDecoder (
    input  isaPkg::opcode_t opcode,  // Top bits of the head word
    ctrlIf.decoder          ctrl
);
    import isaPkg::*;

    localparam aluOp_t aluAddi = 5'b01000;  // Address add for jumps, loads, stores
    localparam aluOp_t aluNop  = 5'b00001;

    always_comb begin
        // Baseline is a harmless no-write bundle
        ctrl.regWrite   = 1'b0;
        ctrl.destRegSel = 2'b11;       // Rd-I
        ctrl.regJump    = 1'b0;
        ctrl.memEnable  = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.memToReg   = 1'b0;        // ALU result to register
        ctrl.aluImm     = 1'b1;
        ctrl.aluOp      = opcode;      // Pass through by default
        ctrl.immSel     = 3'b100;      // Signed 5 bits
        ctrl.linkSel    = 2'b00;
        ctrl.isBranch   = 1'b0;
        ctrl.isHalt     = 1'b0;
        ctrl.siic       = 1'b0;
        ctrl.rti        = 1'b0;

        casez (opcode)
            5'b000??: begin  // Special group, no state change
                ctrl.regWrite  = 1'b0;
                ctrl.memEnable = 1'b0;
                ctrl.memWrite  = 1'b0;
                case (opcode[1:0])
                    2'b00: ctrl.isHalt = 1'b1;  // HALT
                    2'b01: ctrl.aluOp  = opcode;  // NOP
                    2'b10: ctrl.siic   = 1'b1;  // SIIC
                    default: begin  // RTI behaves as NOP
                        ctrl.rti   = 1'b1;
                        ctrl.aluOp = aluNop;
                    end
                endcase
            end
            5'b010??, 5'b101??: begin  // I-format 1 arithmetic and logic
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b11;  // Rd-I
                ctrl.aluImm     = 1'b1;
                ctrl.immSel     = opcode[1] ? 3'b000 : 3'b100;  // Logic ops zero extend
            end
            5'b1000?: begin  // ST and LD
                ctrl.aluOp     = aluAddi;  // Effective address
                ctrl.aluImm    = 1'b1;
                ctrl.immSel    = 3'b100;
                ctrl.memEnable = 1'b1;
                if (opcode[0]) begin  // LD
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                end else begin  // ST
                    ctrl.memWrite = 1'b1;
                end
            end
            5'b10011: begin  // STU stores and updates Rs
                ctrl.aluOp      = aluAddi;
                ctrl.aluImm     = 1'b1;
                ctrl.immSel     = 3'b100;
                ctrl.memEnable  = 1'b1;
                ctrl.memWrite   = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b00;  // Rs
            end
            5'b11001, 5'b1101?, 5'b111??: begin  // R format, LBI excluded
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b01;  // Rd-R
                ctrl.aluImm     = 1'b0;   // Register operand
                ctrl.immSel     = 3'b000;
            end
            5'b011??: begin  // Conditional branches
                ctrl.immSel     = 3'b101;  // Signed 8 bits
                ctrl.isBranch   = 1'b1;
                ctrl.aluImm     = 1'b0;    // ALU tests Rs
                ctrl.destRegSel = 2'b00;
            end
            5'b11000: begin  // LBI
                ctrl.immSel     = 3'b101;  // Signed 8 bits
                ctrl.linkSel    = 2'b01;
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b00;   // Rs
            end
            5'b10010: begin  // SLBI shifts Rs and ors in the byte
                ctrl.immSel     = 3'b001;  // Unsigned 8 bits
                ctrl.regWrite   = 1'b1;
                ctrl.destRegSel = 2'b00;   // Rs
            end
            5'b001??: begin  // J, JR, JAL, JALR
                ctrl.destRegSel = 2'b10;    // R7 for link
                ctrl.aluOp      = aluAddi;
                ctrl.isBranch   = 1'b1;
                ctrl.regJump    = opcode[0];  // JR and JALR use Rs
                ctrl.immSel     = opcode[0] ? 3'b101 : 3'b110;  // 8 or 11 bits signed
                if (opcode[1]) begin  // Linking forms
                    ctrl.linkSel  = 2'b10;
                    ctrl.regWrite = 1'b1;
                end
            end
        endcase
    end

endmodule

/* design/creditCounter.sv */
// Downstream credit counter, down on issue and up on credit return
`timescale 1ns/1ps
`include "decode_consts.svh"

module creditCounter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  consume,    // Bundle issued
    input  logic                  restore,    // Receiver freed a slot
    output flowPkg::creditCount_t available
);
    import isaPkg::*;
    import flowPkg::*;

    localparam creditCount_t maxCredits = creditCount_t'(`DOWNSTREAM_CREDITS);

    always_ff @(posedge clk) begin
        if (reset) begin
            available <= maxCredits;  // Receiver starts empty
        end else begin
            case ({consume, restore})
                2'b10:   available <= available - 1'b1;
                2'b01:   available <= available + 1'b1;
                default: available <= available;  // Both cancel out
            endcase
        end
    end

    // Receiver never returns more slots than it offered
    assert property (@(posedge clk) disable iff (reset) available <= maxCredits)
        else $error("creditCounter: credit count above initial value");

    // Sequencer must hold a credit before issuing
    assert property (@(posedge clk) disable iff (reset) consume |-> available != '0)
        else $error("creditCounter: issue with no credit");

endmodule

/* design/ctrlIf.sv */
// Decoded control bundle interface with decoder and consumer modports
`timescale 1ns/1ps

interface ctrlIf;
    import isaPkg::*;

    logic        regWrite;    // Register file write
    destRegSel_t destRegSel;  // Write register choice
    logic        regJump;     // Target from Rs plus immediate
    logic        memEnable;   // Data memory access
    logic        memWrite;    // Data memory store
    logic        memToReg;    // Write back load data
    logic        aluImm;      // ALU B operand is the immediate
    aluOp_t      aluOp;       // ALU operation
    immSel_t     immSel;      // Immediate size and sign
    linkSel_t    linkSel;     // Link or LBI write back
    logic        isBranch;    // Jump or branch group
    logic        isHalt;      // HALT opcode
    logic        siic;        // SIIC opcode
    logic        rti;         // RTI, treated as NOP

    // Combinational producer side
    modport decoder (
        output regWrite, destRegSel, regJump, memEnable, memWrite, memToReg,
               aluImm, aluOp, immSel, linkSel, isBranch, isHalt, siic, rti
    );

    // Issue side; immSel is used by the extender before issue
    modport consumer (
        input regWrite, destRegSel, regJump, memEnable, memWrite, memToReg,
              aluImm, aluOp, linkSel, isBranch, isHalt, siic, rti
    );

endinterface

/* design/decodeUnit.sv */
// Decode stage top wiring queue, decoder, extender, credit counter and sequencer
`timescale 1ns/1ps

module decodeUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                inValid,
    input  isaPkg::instrWord_t  inInstr,
    output logic                inCredit,
    output logic                outValid,
    output logic                regWrite,
    output isaPkg::destRegSel_t destRegSel,
    output logic                regJump,
    output logic                memEnable,
    output logic                memWrite,
    output logic                memToReg,
    output logic                aluImm,
    output isaPkg::aluOp_t      aluOp,
    output isaPkg::linkSel_t    linkSel,
    output logic                isBranch,
    output logic                siic,
    output logic                rti,
    output isaPkg::dataWord_t   outImmediate,
    input  logic                outCredit,
    input  logic                resume,
    output logic                halted
);
    import isaPkg::*;
    import flowPkg::*;

    logic         queueEmpty;
    instrWord_t   headWord;          // Word being decoded
    logic         pop;
    dataWord_t    immediate;         // Extended head immediate
    creditCount_t creditsAvailable;

    ctrlIf ctrlBus ();  // Decoder to sequencer bundle

    instrQueue queue (
        .clk(clk), .reset(reset),
        .pushValid(inValid), .pushWord(inInstr),
        .pop(pop), .empty(queueEmpty), .headWord(headWord),
        .credit(inCredit)
    );

    controlDecoder decoder (.opcode(opcodeOf(headWord)), .ctrl(ctrlBus.decoder));

    immExtender extender (.instr(headWord), .immSel(ctrlBus.immSel), .immediate(immediate));

    creditCounter credits (
        .clk(clk), .reset(reset),
        .consume(pop), .restore(outCredit), .available(creditsAvailable)
    );

    issueSequencer sequencer (
        .clk(clk), .reset(reset),
        .ctrl(ctrlBus.consumer), .immediate(immediate),
        .queueEmpty(queueEmpty), .creditsAvailable(creditsAvailable),
        .resume(resume), .pop(pop), .outValid(outValid),
        .regWrite(regWrite), .destRegSel(destRegSel), .regJump(regJump),
        .memEnable(memEnable), .memWrite(memWrite), .memToReg(memToReg),
        .aluImm(aluImm), .aluOp(aluOp), .linkSel(linkSel), .isBranch(isBranch),
        .siic(siic), .rti(rti), .outImmediate(outImmediate), .halted(halted)
    );

endmodule

/* design/flowPkg.sv */
// Sequencer state enum and credit count type
`include "decode_consts.svh"

package flowPkg;

    // Issue sequencer states
    typedef enum logic {
        RUN,    // Issuing whenever a word and a credit are there
        HALTED  // Parked after HALT until resume
    } seqState_t;

    // Wide enough for the larger of queue depth and downstream credits
    typedef logic [$clog2(
        ((`INSTR_QUEUE_DEPTH > `DOWNSTREAM_CREDITS) ?
            `INSTR_QUEUE_DEPTH : `DOWNSTREAM_CREDITS) + 1) - 1:0] creditCount_t;

endpackage

/* design/immExtender.sv */
// Immediate field select with sign or zero extension to a full word
`timescale 1ns/1ps
`include "decode_consts.svh"

module immExtender (
    input  isaPkg::instrWord_t instr,
    input  isaPkg::immSel_t    immSel,     // Signed bit and size code
    output isaPkg::dataWord_t  immediate
);
    import isaPkg::*;

    logic signExt;  // Replicate the field's top bit
    logic fillBit;  // Value of the upper bits

    assign signExt = immSel[2];

    always_comb begin
        case (immSel[1:0])
            2'd0: begin  // 5 bit field
                fillBit   = signExt & instr[4];
                immediate = {{(`WORD_WIDTH - 5){fillBit}}, instr[4:0]};
            end
            2'd1: begin  // 8 bit field
                fillBit   = signExt & instr[7];
                immediate = {{(`WORD_WIDTH - 8){fillBit}}, instr[7:0]};
            end
            default: begin  // 11 bit displacement
                fillBit   = signExt & instr[10];
                immediate = {{(`WORD_WIDTH - 11){fillBit}}, instr[10:0]};
            end
        endcase
    end

endmodule

/* design/instrQueue.sv */
// Circular instruction FIFO returning one upstream credit per pop
`timescale 1ns/1ps
`include "decode_consts.svh"

module instrQueue (
    input  logic               clk,
    input  logic               reset,
    input  logic               pushValid,  // Fetch side word strobe
    input  isaPkg::instrWord_t pushWord,
    input  logic               pop,        // Head consumed by the sequencer
    output logic               empty,
    output isaPkg::instrWord_t headWord,
    output logic               credit      // One-cycle upstream credit
);
    import isaPkg::*;

    localparam int depth      = `INSTR_QUEUE_DEPTH;
    localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);

    instrWord_t            mem [depth];  // Word storage
    logic [ptrWidth-1:0]   rdPtr;        // Head slot
    logic [ptrWidth-1:0]   wrPtr;        // Next free slot
    logic [countWidth-1:0] count;        // Occupancy
    logic                  full;

    assign empty    = (count == '0);
    assign full     = (count == countWidth'(depth));
    assign headWord = mem[rdPtr];  // Visible right after the push edge

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushWord;  // Storage, no reset
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdPtr  <= '0;
            wrPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;  // Slot freed, hand it back next cycle
            if (pushValid) begin
                wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;  // Wrap
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or both
            endcase
        end
    end

    // Fetch side must hold a credit for every word it sends
    assert property (@(posedge clk) disable iff (reset) pushValid |-> !full)
        else $error("instrQueue: push while full");

    // Sequencer may only issue a word that is there
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("instrQueue: pop while empty");

endmodule

/* design/isaPkg.sv */
// ISA types for words, opcodes, ALU codes and select fields, plus opcode extraction
`include "decode_consts.svh"

package isaPkg;

    // Raw instruction word as fetched
    typedef logic [`WORD_WIDTH-1:0] instrWord_t;

    // Top five bits of the word
    typedef logic [4:0] opcode_t;

    // ALU operation code, mostly the opcode itself
    typedef logic [4:0] aluOp_t;

    // Bit 2 is signed, bits 1:0 give size
    // Size 0 is 5 bits, 1 is 8 bits, 2 is 11 bits
    typedef logic [2:0] immSel_t;

    // 0 Rs, 1 Rd of R format, 2 R7, 3 Rd of I format
    typedef logic [1:0] destRegSel_t;

    // 0 none, 1 LBI, 2 link
    typedef logic [1:0] linkSel_t;

    // Extended immediate and datapath word
    typedef logic [`WORD_WIDTH-1:0] dataWord_t;

    // Opcode sits in the top five bits of every format
    function automatic opcode_t opcodeOf(input instrWord_t word);
        return word[`WORD_WIDTH-1 -: 5];
    endfunction

endpackage

/* design/issueSequencer.sv */
// Run and halt FSM issuing decoded bundles through output registers
`timescale 1ns/1ps

module issueSequencer (
    input  logic                  clk,
    input  logic                  reset,
    ctrlIf.consumer               ctrl,
    input  isaPkg::dataWord_t     immediate,
    input  logic                  queueEmpty,
    input  flowPkg::creditCount_t creditsAvailable,
    input  logic                  resume,        // Leave HALTED
    output logic                  pop,           // Issue strobe, also consumes a credit
    output logic                  outValid,
    output logic                  regWrite,
    output isaPkg::destRegSel_t   destRegSel,
    output logic                  regJump,
    output logic                  memEnable,
    output logic                  memWrite,
    output logic                  memToReg,
    output logic                  aluImm,
    output isaPkg::aluOp_t        aluOp,
    output isaPkg::linkSel_t      linkSel,
    output logic                  isBranch,
    output logic                  siic,
    output logic                  rti,
    output isaPkg::dataWord_t     outImmediate,
    output logic                  halted
);
    import isaPkg::*;
    import flowPkg::*;

    seqState_t state;
    seqState_t nextState;
    logic      issue;

    assign issue  = (state == RUN) && !queueEmpty && (creditsAvailable != '0);
    assign pop    = issue;
    assign halted = (state == HALTED);

    always_comb begin
        nextState = state;
        case (state)
            RUN:     if (issue && ctrl.isHalt) nextState = HALTED;  // HALT itself goes out
            HALTED:  if (resume) nextState = RUN;
            default: nextState = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= RUN;
            outValid <= 1'b0;
        end else begin
            state    <= nextState;
            outValid <= issue;  // Single-cycle valid per bundle
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin  // Payload capture, qualified by outValid
            regWrite     <= ctrl.regWrite;
            destRegSel   <= ctrl.destRegSel;
            regJump      <= ctrl.regJump;
            memEnable    <= ctrl.memEnable;
            memWrite     <= ctrl.memWrite;
            memToReg     <= ctrl.memToReg;
            aluImm       <= ctrl.aluImm;
            aluOp        <= ctrl.aluOp;
            linkSel      <= ctrl.linkSel;
            isBranch     <= ctrl.isBranch;
            siic         <= ctrl.siic;
            rti          <= ctrl.rti;
            outImmediate <= immediate;
        end
    end

    // Stray resume while running is ignored unless HALT goes out that cycle
    assert property (@(posedge clk) disable iff (reset)
        (state == RUN && resume && !(issue && ctrl.isHalt)) |=> state == RUN)
        else $error("issueSequencer: resume changed state while running");

endmodule

/* dv/decodeUnitTb.sv */
// Decode stage testbench with reference decode, fetch and receiver models, and compare process
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeUnitTb;

    localparam logic [4:0] addiCode = 5'b01000;  // ALU code for address adds
    localparam logic [4:0] nopCode  = 5'b00001;
    localparam int waitLimit = 2000;               // Cycles allowed per wait loop

    typedef struct packed {
        logic       regWrite;
        logic [1:0] destRegSel;
        logic       regJump;
        logic       memEnable;
        logic       memWrite;
        logic       memToReg;
        logic       aluImm;
        logic [4:0] aluOp;
        logic [1:0] linkSel;
        logic       isBranch;
        logic       siic;
        logic       rti;
        logic [15:0] immediate;
    } bundle_t;

    logic clk = 1'b0;
    logic reset, inValid, inCredit, outValid, outCredit, resume, halted;
    logic [15:0] inInstr, outImmediate;
    logic regWrite, regJump, memEnable, memWrite, memToReg, aluImm, isBranch, siic, rti;
    logic [1:0] destRegSel, linkSel;
    logic [4:0] aluOp;

    logic [15:0] expectedQ[$];   // Words sent, in issue order
    int wordsSent = 0;
    int upstreamBack = 0;        // inCredit pulses seen
    int issuedCount = 0;         // outValid bundles seen
    int returnedCount = 0;       // outCredit pulses driven
    int mismatchCount = 0;
    int otherErrors = 0;
    logic withholdCredits = 1'b0;  // Receiver keeps its slots
    logic holdExpected = 1'b0;     // No bundle may appear

    decodeUnit uut (.*);

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
            mismatchCount++;
        end
    endtask

    // Expected fields straight from the opcode table
    function automatic bundle_t refDecode(input logic [15:0] word);
        bundle_t b;
        logic [4:0] op;
        logic immSigned;
        int immBits;
        logic [15:0] mask;
        op = word[15:11];
        b = '0;
        b.destRegSel = 2'd3;  // Rd of I format unless changed
        b.aluImm = 1'b1;
        b.aluOp = op;
        immSigned = 1'b1;
        immBits = 5;
        casez (op)
            5'b000??: begin  // HALT, NOP, SIIC, RTI
                b.siic = (op[1:0] == 2'b10);
                b.rti = (op[1:0] == 2'b11);
                if (b.rti)
                    b.aluOp = nopCode;
            end
            5'b010??, 5'b101??: begin
                b.regWrite = 1'b1;
                immSigned = !op[1];  // Logic forms zero extend
            end
            5'b10000, 5'b10001: begin  // ST, LD
                b.aluOp = addiCode;
                b.memEnable = 1'b1;
                b.memWrite = !op[0];
                b.regWrite = op[0];
                b.memToReg = op[0];
            end
            5'b10011: begin  // STU
                b.aluOp = addiCode;
                b.memEnable = 1'b1;
                b.memWrite = 1'b1;
                b.regWrite = 1'b1;
                b.destRegSel = 2'd0;
            end
            5'b11001, 5'b1101?, 5'b111??: begin
                b.regWrite = 1'b1;
                b.destRegSel = 2'd1;
                b.aluImm = 1'b0;
                immSigned = 1'b0;
            end
            5'b011??: begin  // Branches
                immBits = 8;
                b.isBranch = 1'b1;
                b.aluImm = 1'b0;
                b.destRegSel = 2'd0;
            end
            5'b11000: begin  // LBI
                immBits = 8;
                b.linkSel = 2'd1;
                b.regWrite = 1'b1;
                b.destRegSel = 2'd0;
            end
            5'b10010: begin  // SLBI
                immBits = 8;
                immSigned = 1'b0;
                b.regWrite = 1'b1;
                b.destRegSel = 2'd0;
            end
            5'b001??: begin  // Jumps
                b.destRegSel = 2'd2;
                b.aluOp = addiCode;
                b.isBranch = 1'b1;
                b.regJump = op[0];
                immBits = op[0] ? 8 : 11;
                b.linkSel = op[1] ? 2'd2 : 2'd0;
                b.regWrite = op[1];
            end
        endcase
        mask = (16'd1 << immBits) - 16'd1;
        b.immediate = word & mask;
        if (immSigned && word[immBits-1])
            b.immediate = b.immediate | ~mask;  // Sign fill
        return b;
    endfunction

    function automatic logic [15:0] randomWord();
        logic [4:0] op;
        op = 5'(1 + ($urandom % 31));  // Anything but HALT
        return {op, 11'($urandom)};
    endfunction

    // Fetch model, pushes only while it holds an upstream credit
    task automatic sendWord(input logic [15:0] word);
        int cycles;
        cycles = 0;
        while (wordsSent - upstreamBack >= `INSTR_QUEUE_DEPTH && cycles < waitLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("ERROR: timeout waiting for an upstream credit");
            otherErrors++;
        end
        inValid = 1'b1;
        inInstr = word;
        expectedQ.push_back(word);
        wordsSent++;
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic waitIssued(input int target, input string what);
        int cycles;
        cycles = 0;
        while (issuedCount < target && cycles < waitLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("ERROR: timeout waiting for %s to issue", what);
            otherErrors++;
        end
    endtask

    task automatic waitReturned();
        int cycles;
        cycles = 0;
        while (returnedCount < issuedCount && cycles < waitLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("ERROR: timeout waiting for the receiver to return its slots");
            otherErrors++;
        end
    endtask

    task automatic waitHalted();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < waitLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("ERROR: timeout waiting for halted after HALT");
            otherErrors++;
        end
    endtask

    task automatic waitUpstreamBack();
        int cycles;
        cycles = 0;
        while (upstreamBack < wordsSent && cycles < waitLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("ERROR: timeout waiting for the last inCredit pulses");
            otherErrors++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && inCredit) begin
            if (upstreamBack >= wordsSent) begin  // Only sent words earn a credit
                $display("ERROR: inCredit pulse with no word outstanding at %0t", $time);
                otherErrors++;
            end
            upstreamBack <= upstreamBack + 1;  // Counted at the edge
        end
    end

    // Receiver model, returns slots after random delays
    initial begin
        outCredit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && !withholdCredits && returnedCount < issuedCount
                && ($urandom % 3) == 0) begin
                outCredit = 1'b1;
                returnedCount++;
            end else begin
                outCredit = 1'b0;
            end
        end
    end

    // Compare process, one expected word per bundle
    always @(posedge clk) begin
        bundle_t exp;
        if (!reset && outValid) begin
            if (holdExpected) begin
                $display("ERROR: outValid while the sequencer should be halted");
                otherErrors++;
            end
            if (issuedCount - returnedCount >= `DOWNSTREAM_CREDITS) begin
                $display("ERROR: bundle issued without a downstream credit");
                otherErrors++;
            end
            if (expectedQ.size() == 0) begin
                $display("ERROR: outValid with no word pending");
                otherErrors++;
            end else begin
                exp = refDecode(expectedQ.pop_front());
                checkValue("regWrite", regWrite, exp.regWrite);
                checkValue("destRegSel", destRegSel, exp.destRegSel);
                checkValue("regJump", regJump, exp.regJump);
                checkValue("memEnable", memEnable, exp.memEnable);
                checkValue("memWrite", memWrite, exp.memWrite);
                checkValue("memToReg", memToReg, exp.memToReg);
                checkValue("aluImm", aluImm, exp.aluImm);
                checkValue("aluOp", aluOp, exp.aluOp);
                checkValue("linkSel", linkSel, exp.linkSel);
                checkValue("isBranch", isBranch, exp.isBranch);
                checkValue("siic", siic, exp.siic);
                checkValue("rti", rti, exp.rti);
                checkValue("outImmediate", outImmediate, exp.immediate);
            end
            issuedCount <= issuedCount + 1;
        end
    end

    initial begin
        int base;
        void'($urandom(49873));
        reset = 1'b1;
        inValid = 1'b0;
        inInstr = '0;
        resume = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValue("outValid", outValid, 0);  // Quiet after reset
        checkValue("inCredit", inCredit, 0);
        checkValue("halted", halted, 0);

        for (int i = 0; i < 40; i++)
            sendWord(randomWord());  // Random fields for the extension rules
        waitIssued(wordsSent, "random words");

        waitReturned();  // Full downstream credit before back-pressure
        withholdCredits = 1'b1;
        base = issuedCount;
        for (int i = 0; i < 2 * `DOWNSTREAM_CREDITS; i++)
            sendWord(randomWord());
        waitIssued(base + `DOWNSTREAM_CREDITS, "credited words");
        repeat (20) @(posedge clk);
        #1;
        checkValue("bundles with credit withheld", issuedCount - base, `DOWNSTREAM_CREDITS);
        withholdCredits = 1'b0;
        waitIssued(wordsSent, "back-pressured words");

        for (int op = 1; op < 32; op++)
            sendWord({5'(op), 11'($urandom)});
        sendWord({5'b00000, 11'($urandom)});  // HALT last
        waitIssued(wordsSent, "opcode sweep");
        waitHalted();

        holdExpected = 1'b1;
        base = issuedCount;
        for (int i = 0; i < 3; i++)
            sendWord(randomWord());
        repeat (15) @(posedge clk);
        #1;
        checkValue("bundles while halted", issuedCount - base, 0);
        holdExpected = 1'b0;
        resume = 1'b1;
        @(posedge clk);
        #1;
        resume = 1'b0;
        waitIssued(wordsSent, "words after resume");
        checkValue("halted", halted, 0);

        waitUpstreamBack();
        checkValue("inCredit pulses", upstreamBack, issuedCount);

        $display("Checked %0d bundles: %0d mismatches, %0d other errors",
                 issuedCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
design/isaPkg.sv
design/flowPkg.sv
design/ctrlIf.sv
design/instrQueue.sv
design/controlDecoder.sv
design/immExtender.sv
design/creditCounter.sv
design/issueSequencer.sv
design/decodeUnit.sv
dv/decodeUnitTb.sv

/* include/decode_consts.svh */
// Queue depth, downstream credit count and word width macros
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Instruction queue entries, also the upstream credit count
`define INSTR_QUEUE_DEPTH 4

// Slots offered by the execute side after reset
`define DOWNSTREAM_CREDITS 4

// Instruction and data word width
`define WORD_WIDTH 16

`endif
